/* Bender.yml */
package:
  name: simt_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/simt_pkg.sv
      - verilog/warp_scheduler.sv
      - verilog/thread_lane.sv
      - verilog/store_drain.sv
      - verilog/compute_core.sv
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/compute_core_tb.sv

/* tb.f */
+incdir+verilog
+incdir+test
verilog/simt_pkg.sv
verilog/warp_scheduler.sv
verilog/thread_lane.sv
verilog/store_drain.sv
verilog/compute_core.sv
test/compute_core_tb.sv

/* test/program_table.svh */
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

localparam int PROG_LEN = 14;
localparam int NUM_CASES = 6;

typedef struct packed {
    logic [1:0] prog;
    logic [2:0] num_warps;
    logic [7:0] base_pc;
    logic [6:0] imem_pct;
    logic [6:0] dmem_pct;
} test_case_t;

// Program, warps, base pc, imem ready %, dmem ready %
localparam test_case_t CASES [NUM_CASES] = '{
    '{2'd0, 3'd4, 8'h00, 7'd100, 7'd100},
    '{2'd0, 3'd2, 8'h00, 7'd100, 7'd100},
    '{2'd0, 3'd4, 8'h00, 7'd50,  7'd40},
    '{2'd1, 3'd3, 8'h40, 7'd70,  7'd60},
    '{2'd1, 3'd1, 8'hc0, 7'd30,  7'd30},
    '{2'd1, 3'd4, 8'h10, 7'd45,  7'd35}
};

function automatic simt_pkg::instr_t encode_instr(input simt_pkg::opcode_t op,
        input int rd, input int rs1, input int rs2, input int imm);
    simt_pkg::instr_t w;
    w.opcode = op;
    w.rd = 4'(rd);
    w.rs1 = 4'(rs1);
    w.rs2 = 4'(rs2);
    w.imm = 16'(imm);
    return w;
endfunction

// Words past the end of a program are HALT
function automatic simt_pkg::instr_t program_word(input int prog, input int idx);
    simt_pkg::instr_t w;
    w = encode_instr(simt_pkg::OP_HALT, 0, 0, 0, 0);
    if (prog == 0) begin
        case (idx)
            0: w = encode_instr(simt_pkg::OP_ADDI, 2, 0, 0, -5);
            1: w = encode_instr(simt_pkg::OP_ADD, 3, 1, 2, 0);
            2: w = encode_instr(simt_pkg::OP_SUB, 4, 2, 1, 0);
            // Write to r1 must be dropped
            3: w = encode_instr(simt_pkg::OP_ADDI, 1, 0, 0, 99);
            4: w = encode_instr(simt_pkg::OP_ADDI, 5, 0, 0, 3);
            5: w = encode_instr(simt_pkg::OP_SLL, 6, 1, 5, 0);
            6: w = encode_instr(simt_pkg::OP_XOR, 7, 6, 4, 0);
            7: w = encode_instr(simt_pkg::OP_OR, 8, 7, 3, 0);
            8: w = encode_instr(simt_pkg::OP_AND, 9, 8, 2, 0);
            9: w = encode_instr(simt_pkg::OP_ADD, 10, 9, 6, 0);
            10: w = encode_instr(simt_pkg::OP_NOP, 0, 0, 0, 0);
            11: w = encode_instr(simt_pkg::OP_STORE, 0, 1, 10, 0);
            12: w = encode_instr(simt_pkg::OP_STORE, 0, 1, 4, 32);
            default: w = encode_instr(simt_pkg::OP_HALT, 0, 0, 0, 0);
        endcase
    end else begin
        case (idx)
            0: w = encode_instr(simt_pkg::OP_ADDI, 2, 1, 0, 100);
            1: w = encode_instr(simt_pkg::OP_SLL, 3, 2, 1, 0);
            2: w = encode_instr(simt_pkg::OP_SUB, 4, 0, 3, 0);
            3: w = encode_instr(simt_pkg::OP_ADDI, 5, 1, 0, -16);
            4: w = encode_instr(simt_pkg::OP_STORE, 0, 5, 4, 80);
            5: w = encode_instr(simt_pkg::OP_XOR, 6, 4, 2, 0);
            6: w = encode_instr(simt_pkg::OP_ADDI, 0, 6, 0, 7);
            7: w = encode_instr(simt_pkg::OP_STORE, 0, 1, 6, 200);
            default: w = encode_instr(simt_pkg::OP_HALT, 0, 0, 0, 0);
        endcase
    end
    return w;
endfunction

`endif

/* test/compute_core_tb.sv */
`timescale 1ns/1ps

`include "simt_consts.svh"

module compute_core_tb;

    localparam int THREADS = `SIMT_THREADS;
    localparam int IMEM_DEPTH = 1 << `SIMT_IMEM_AW;
    localparam int DMEM_DEPTH = 1 << `SIMT_DMEM_AW;
    localparam int DRIVE_DELAY = 10;

    `include "program_table.svh"

    logic                   clk;
    logic                   reset;
    logic                   start;
    simt_pkg::core_config_t cfg;
    logic                   imem_ready;
    simt_pkg::instr_t       imem_data;
    logic                   dmem_ready;
    simt_pkg::imem_req_t    imem_req;
    simt_pkg::dmem_write_t  dmem_write;
    logic                   done;

    // Instruction memory model and the expected image
    simt_pkg::instr_t            imem [IMEM_DEPTH];
    logic [`SIMT_DATA_WIDTH-1:0] exp_data [DMEM_DEPTH];
    bit                          exp_valid [DMEM_DEPTH];
    int                          got_count [DMEM_DEPTH];
    int exp_total;
    int received_total;

    integer seed;
    int imem_pct;
    int dmem_pct;
    logic [`SIMT_IMEM_AW-1:0] cur_base;
    bit running;
    bit fetch_seen;
    bit held_pending;
    simt_pkg::dmem_write_t held_write;
    simt_pkg::imem_req_t want_fetch;
    int cycle_count;
    int timeout_limit;

    compute_core dut_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg),
        .imem_ready (imem_ready),
        .imem_data  (imem_data),
        .dmem_ready (dmem_ready),
        .imem_req   (imem_req),
        .dmem_write (dmem_write),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_done(input logic got, input logic want);
        if (got !== want) begin
            $display("** Error: done = %h, expected %h at %0t", got, want, $time);
            stop_on_error();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
            stop_on_error();
        end
    endtask

    task automatic check_fetch(input simt_pkg::imem_req_t got, input simt_pkg::imem_req_t want);
        if (got !== want) begin
            $display("** Error: imem_req = %h, expected %h at %0t", got, want, $time);
            stop_on_error();
        end
    endtask

    task automatic check_held(input simt_pkg::dmem_write_t got,
            input simt_pkg::dmem_write_t want);
        if (got !== want) begin
            $display("** Error: dmem_write = %h, expected %h while waiting for ready",
                     got, want);
            stop_on_error();
        end
    endtask

    task automatic check_write(input simt_pkg::dmem_write_t got);
        if (!exp_valid[got.addr]) begin
            $display("** Error: dmem_write.addr = %h, no write expected there", got.addr);
            stop_on_error();
        end
        if (got_count[got.addr] != 0) begin
            $display("Address %h was written a second time at %0t", got.addr, $time);
            stop_on_error();
        end
        if (got.data !== exp_data[got.addr]) begin
            $display("** Error: dmem_write.data = %h, expected %h at addr %h",
                     got.data, exp_data[got.addr], got.addr);
            stop_on_error();
        end
        got_count[got.addr]++;
        received_total++;
    endtask

    task automatic load_memories(input int prog, input logic [`SIMT_IMEM_AW-1:0] base);
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            imem[a] = encode_instr(simt_pkg::OP_HALT, 0, 0, 0, 16'h5a00 ^ a);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[`SIMT_IMEM_AW'(base + i)] = program_word(prog, i);
        end
    endtask

    // Reference model, one thread at a time
    task automatic build_expected(input int warps, input logic [`SIMT_IMEM_AW-1:0] base);
        logic [`SIMT_DATA_WIDTH-1:0] regs [`SIMT_NUM_REGS];
        logic [`SIMT_DATA_WIDTH-1:0] a_val;
        logic [`SIMT_DATA_WIDTH-1:0] b_val;
        logic [`SIMT_DATA_WIDTH-1:0] imm_val;
        logic [`SIMT_DATA_WIDTH-1:0] res;
        logic [`SIMT_IMEM_AW-1:0] pc;
        logic [`SIMT_DMEM_AW-1:0] addr;
        simt_pkg::instr_t ins;
        int tid;
        bit halted;
        bit writes;
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            exp_valid[i] = 1'b0;
            got_count[i] = 0;
        end
        exp_total = 0;
        for (int w = 0; w < warps; w++) begin
            for (int l = 0; l < THREADS; l++) begin
                tid = w * THREADS + l;
                foreach (regs[r]) regs[r] = '0;
                pc = base;
                halted = 1'b0;
                for (int step = 0; step < PROG_LEN && !halted; step++) begin
                    ins = imem[pc];
                    a_val = (ins.rs1 == 0) ? '0 : (ins.rs1 == 1) ? 32'(tid) : regs[ins.rs1];
                    b_val = (ins.rs2 == 0) ? '0 : (ins.rs2 == 1) ? 32'(tid) : regs[ins.rs2];
                    imm_val = {{16{ins.imm[15]}}, ins.imm};
                    writes = 1'b1;
                    res = '0;
                    case (ins.opcode)
                        simt_pkg::OP_ADD:  res = a_val + b_val;
                        simt_pkg::OP_SUB:  res = a_val - b_val;
                        simt_pkg::OP_AND:  res = a_val & b_val;
                        simt_pkg::OP_OR:   res = a_val | b_val;
                        simt_pkg::OP_XOR:  res = a_val ^ b_val;
                        simt_pkg::OP_SLL:  res = a_val << b_val[4:0];
                        simt_pkg::OP_ADDI: res = a_val + imm_val;
                        simt_pkg::OP_STORE: begin
                            writes = 1'b0;
                            addr = `SIMT_DMEM_AW'(a_val + imm_val);
                            if (exp_valid[addr]) begin
                                $display("Test table stores twice to address %h", addr);
                                stop_on_error();
                            end
                            exp_valid[addr] = 1'b1;
                            exp_data[addr] = b_val;
                            exp_total++;
                        end
                        simt_pkg::OP_HALT: begin
                            writes = 1'b0;
                            halted = 1'b1;
                        end
                        default: writes = 1'b0;
                    endcase
                    if (writes && ins.rd > 1) begin
                        regs[ins.rd] = res;
                    end
                    pc = pc + 1'b1;
                end
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        start = 1'b0;
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
    endtask

    task automatic run_case(input int c);
        test_case_t tc;
        tc = CASES[c];
        load_memories(int'(tc.prog), tc.base_pc);
        build_expected(int'(tc.num_warps), tc.base_pc);
        apply_reset();
        cur_base = tc.base_pc;
        imem_pct = int'(tc.imem_pct);
        dmem_pct = int'(tc.dmem_pct);
        fetch_seen = 1'b0;
        held_pending = 1'b0;
        received_total = 0;
        // Quiet outputs after reset and before start
        repeat (3) begin
            @(posedge clk);
            check_done(done, 1'b0);
            check_level("imem_req.valid", imem_req.valid, 1'b0);
            check_level("dmem_write.valid", dmem_write.valid, 1'b0);
            #DRIVE_DELAY;
        end
        running = 1'b1;
        cfg.base_pc = tc.base_pc;
        cfg.num_warps = tc.num_warps;
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        @(posedge clk);
        while (done !== 1'b1) @(posedge clk);
        // done is sticky
        repeat (8) begin
            @(posedge clk);
            check_done(done, 1'b1);
        end
        #DRIVE_DELAY;
        running = 1'b0;
    endtask

    // Write capture, hold check and ready generation
    always @(posedge clk) begin
        if (running) begin
            if (done && received_total != exp_total) begin
                $display("done rose after %0d of %0d expected writes", received_total, exp_total);
                stop_on_error();
            end
            if (held_pending) begin
                check_held(dmem_write, held_write);
            end
            if (dmem_write.valid && dmem_ready) begin
                check_write(dmem_write);
            end
            held_pending = dmem_write.valid && !dmem_ready;
            held_write = dmem_write;
            if (!fetch_seen && imem_req.valid) begin
                want_fetch.valid = 1'b1;
                want_fetch.addr = cur_base;
                check_fetch(imem_req, want_fetch);
                fetch_seen = 1'b1;
            end
        end
        #DRIVE_DELAY;
        if (running) begin
            imem_ready = ($unsigned($random(seed)) % 100) < imem_pct;
            dmem_ready = ($unsigned($random(seed)) % 100) < dmem_pct;
        end else begin
            imem_ready = 1'b0;
            dmem_ready = 1'b0;
        end
        imem_data = imem[imem_req.addr];
    end

    always @(posedge clk) begin
        if (running) begin
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                $display("Timeout: the core never finished within %0d cycles", timeout_limit);
                stop_on_error();
            end
        end
    end

    initial begin
        seed = 32'ha385a4f2;
        reset = 1'b1;
        start = 1'b0;
        cfg = '0;
        imem_ready = 1'b0;
        imem_data = '0;
        dmem_ready = 1'b0;
        running = 1'b0;
        fetch_seen = 1'b0;
        held_pending = 1'b0;
        held_write = '0;
        want_fetch = '0;
        cur_base = '0;
        imem_pct = 0;
        dmem_pct = 0;
        exp_total = 0;
        received_total = 0;
        cycle_count = 0;
        timeout_limit = 0;
        for (int c = 0; c < NUM_CASES; c++) begin
            timeout_limit += PROG_LEN * int'(CASES[c].num_warps) * (8 + THREADS) * 4;
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* verilog/compute_core.sv */
`timescale 1ns/1ps

`include "simt_consts.svh"

module compute_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  simt_pkg::core_config_t cfg,
    input  logic                   imem_ready,
    input  simt_pkg::instr_t       imem_data,
    input  logic                   dmem_ready,
    output simt_pkg::imem_req_t    imem_req,
    output simt_pkg::dmem_write_t  dmem_write,
    output logic                   done
);

    simt_pkg::issue_t     issue;
    simt_pkg::store_req_t lane_reqs [`SIMT_THREADS];
    logic                 drain_busy;

    warp_scheduler u_scheduler (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg),
        .imem_ready (imem_ready),
        .imem_data  (imem_data),
        .drain_busy (drain_busy),
        .imem_req   (imem_req),
        .issue      (issue),
        .done       (done)
    );

    // One lane per thread of a warp
    for (genvar i = 0; i < `SIMT_THREADS; i++) begin : g_lane
        thread_lane #(
            .LANE (i)
        ) u_lane (
            .clk       (clk),
            .reset     (reset),
            .issue     (issue),
            .store_req (lane_reqs[i])
        );
    end

    store_drain u_drain (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .lane_reqs  (lane_reqs),
        .dmem_ready (dmem_ready),
        .dmem_write (dmem_write),
        .drain_busy (drain_busy)
    );

endmodule

/* verilog/simt_consts.svh */
`ifndef SIMT_CONSTS_SVH
`define SIMT_CONSTS_SVH

// Core geometry
`define SIMT_WARPS 4
`define SIMT_THREADS 4

// Datapath word width
`define SIMT_DATA_WIDTH 32

// Registers held by every thread for every warp
`define SIMT_NUM_REGS 16

// Memory address widths
`define SIMT_IMEM_AW 8
`define SIMT_DMEM_AW 8

// Enough bits to name any warp
`define SIMT_WARP_IDX_W 2

`endif

/* verilog/simt_pkg.sv */
package simt_pkg;

    `include "simt_consts.svh"

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_SLL   = 4'd6,
        OP_ADDI  = 4'd7,
        OP_STORE = 4'd8,
        OP_HALT  = 4'd9
    } opcode_t;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_EXECUTE,
        WARP_DONE
    } warp_state_t;

    // Instruction word as it sits in instruction memory
    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] imm;
    } instr_t;

    // Decoded instruction broadcast to all lanes
    typedef struct packed {
        logic                              valid;
        logic [`SIMT_WARP_IDX_W-1:0]       warp;
        opcode_t                           opcode;
        logic [3:0]                        rd;
        logic [3:0]                        rs1;
        logic [3:0]                        rs2;
        logic [`SIMT_DATA_WIDTH-1:0]       imm;
    } issue_t;

    typedef struct packed {
        logic [`SIMT_DMEM_AW-1:0]    addr;
        logic [`SIMT_DATA_WIDTH-1:0] data;
    } store_req_t;

    // num_warps runs from 1 up to the full warp count
    typedef struct packed {
        logic [`SIMT_IMEM_AW-1:0]  base_pc;
        logic [`SIMT_WARP_IDX_W:0] num_warps;
    } core_config_t;

    typedef struct packed {
        logic                     valid;
        logic [`SIMT_IMEM_AW-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic                        valid;
        logic [`SIMT_DMEM_AW-1:0]    addr;
        logic [`SIMT_DATA_WIDTH-1:0] data;
    } dmem_write_t;

endpackage

/* verilog/store_drain.sv */
`timescale 1ns/1ps

`include "simt_consts.svh"

module store_drain (
    input  logic                  clk,
    input  logic                  reset,
    input  simt_pkg::issue_t      issue,
    input  simt_pkg::store_req_t  lane_reqs [`SIMT_THREADS],
    input  logic                  dmem_ready,
    output simt_pkg::dmem_write_t dmem_write,
    output logic                  drain_busy
);

    localparam int THREADS = `SIMT_THREADS;
    localparam int IDX_W = (THREADS > 1) ? $clog2(THREADS) : 1;

    // Captured writes of one warp
    simt_pkg::store_req_t reqs_q [THREADS];

    logic [IDX_W-1:0] lane_idx;
    logic             capture;
    logic             write_fire;
    logic             last_lane;

    assign capture    = issue.valid && (issue.opcode == simt_pkg::OP_STORE);
    assign write_fire = drain_busy && dmem_ready;
    assign last_lane  = (lane_idx == IDX_W'(THREADS - 1));

    always_ff @(posedge clk) begin
        if (capture) begin
            for (int i = 0; i < THREADS; i++) begin
                reqs_q[i] <= lane_reqs[i];
            end
        end
    end

    // Scheduler never issues a store while busy
    always_ff @(posedge clk) begin
        if (reset) begin
            drain_busy <= 1'b0;
            lane_idx <= '0;
        end else if (capture) begin
            drain_busy <= 1'b1;
            lane_idx <= '0;
        end else if (write_fire) begin
            if (last_lane) begin
                drain_busy <= 1'b0;
                lane_idx <= '0;
            end else begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

    always_comb begin
        dmem_write.valid = drain_busy;
        dmem_write.addr  = reqs_q[lane_idx].addr;
        dmem_write.data  = reqs_q[lane_idx].data;
    end

    // Write held steady until the memory takes it
    dmem_write_stable: assert property (
        @(posedge clk) disable iff (reset)
        dmem_write.valid && !dmem_ready |=> $stable(dmem_write)
    );

endmodule

/* verilog/thread_lane.sv */
`timescale 1ns/1ps

`include "simt_consts.svh"

module thread_lane #(
    parameter int LANE = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  simt_pkg::issue_t      issue,
    output simt_pkg::store_req_t  store_req
);

    localparam int DW = `SIMT_DATA_WIDTH;

    // One register set per warp for this thread
    logic [DW-1:0] regs [`SIMT_WARPS][`SIMT_NUM_REGS];

    logic [DW-1:0] thread_id;
    logic [DW-1:0] rs1_val;
    logic [DW-1:0] rs2_val;
    logic [DW-1:0] alu_result;
    logic [DW-1:0] store_addr_full;
    logic          writes_rd;

    assign thread_id = DW'(issue.warp) * DW'(`SIMT_THREADS) + DW'(LANE);

    // r0 is zero and r1 is the thread id
    function automatic logic [DW-1:0] read_reg(input logic [3:0] idx);
        logic [DW-1:0] value;
        case (idx)
            4'd0: value = '0;
            4'd1: value = thread_id;
            default: value = regs[issue.warp][idx];
        endcase
        return value;
    endfunction

    always_comb begin
        rs1_val = read_reg(issue.rs1);
        rs2_val = read_reg(issue.rs2);
    end

    always_comb begin
        writes_rd = 1'b1;
        case (issue.opcode)
            simt_pkg::OP_ADD:  alu_result = rs1_val + rs2_val;
            simt_pkg::OP_SUB:  alu_result = rs1_val - rs2_val;
            simt_pkg::OP_AND:  alu_result = rs1_val & rs2_val;
            simt_pkg::OP_OR:   alu_result = rs1_val | rs2_val;
            simt_pkg::OP_XOR:  alu_result = rs1_val ^ rs2_val;
            simt_pkg::OP_SLL:  alu_result = rs1_val << rs2_val[4:0];
            simt_pkg::OP_ADDI: alu_result = rs1_val + issue.imm;
            default: begin
                alu_result = '0;
                writes_rd = 1'b0;
            end
        endcase
    end

    // Writeback at the end of the issue cycle, r0 and r1 stay fixed
    always_ff @(posedge clk) begin
        if (!reset && issue.valid && writes_rd && issue.rd > 4'd1) begin
            regs[issue.warp][issue.rd] <= alu_result;
        end
    end

    // Store address and data, sampled by the drain on issue
    assign store_addr_full = rs1_val + issue.imm;

    always_comb begin
        store_req.addr = store_addr_full[`SIMT_DMEM_AW-1:0];
        store_req.data = rs2_val;
    end

endmodule

/* verilog/warp_scheduler.sv */
`timescale 1ns/1ps

`include "simt_consts.svh"

module warp_scheduler (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  simt_pkg::core_config_t cfg,
    input  logic                   imem_ready,
    input  simt_pkg::instr_t       imem_data,
    input  logic                   drain_busy,
    output simt_pkg::imem_req_t    imem_req,
    output simt_pkg::issue_t       issue,
    output logic                   done
);

    localparam int WARPS = `SIMT_WARPS;
    localparam int IW = `SIMT_WARP_IDX_W;
    localparam int DW = `SIMT_DATA_WIDTH;

    // Per-warp control
    simt_pkg::warp_state_t     warp_state [WARPS];
    logic [`SIMT_IMEM_AW-1:0]  pc [WARPS];

    logic [IW-1:0] cur_warp;
    logic [IW:0]   num_warps_q;
    logic          started;

    // Fetched word and its decoded form for the selected warp
    simt_pkg::instr_t instr_q;
    simt_pkg::issue_t decoded_q;

    simt_pkg::warp_state_t cur_state;
    logic                  fetch_fire;
    logic                  is_store;
    logic                  is_halt;
    logic                  exec_fire;
    logic                  all_done;
    logic [IW-1:0]         next_warp;
    logic [IW-1:0]         cand;
    logic                  next_found;

    assign cur_state = warp_state[cur_warp];

    always_comb begin
        imem_req.valid = (cur_state == simt_pkg::WARP_FETCH);
        imem_req.addr  = pc[cur_warp];
    end

    assign fetch_fire = imem_req.valid && imem_ready;

    assign is_store = (decoded_q.opcode == simt_pkg::OP_STORE);
    assign is_halt  = (decoded_q.opcode == simt_pkg::OP_HALT);

    // A store holds in execute until the drain has room
    assign exec_fire = (cur_state == simt_pkg::WARP_EXECUTE) && !(is_store && drain_busy);

    always_comb begin
        issue = decoded_q;
        issue.valid = exec_fire;
    end

    // Round-robin pick, current warp is checked last
    always_comb begin
        next_warp = cur_warp;
        next_found = 1'b0;
        cand = cur_warp;
        for (int j = 1; j <= WARPS; j++) begin
            cand = IW'(int'(cur_warp) + j);
            if (!next_found) begin
                if (cand == cur_warp) begin
                    if (!is_halt) begin
                        next_found = 1'b1;
                        next_warp = cand;
                    end
                end else if (warp_state[cand] == simt_pkg::WARP_FETCH) begin
                    next_found = 1'b1;
                    next_warp = cand;
                end
            end
        end
    end

    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < WARPS; i++) begin
            if (i < int'(num_warps_q) && warp_state[i] != simt_pkg::WARP_DONE) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < WARPS; i++) begin
                warp_state[i] <= simt_pkg::WARP_IDLE;
                pc[i] <= '0;
            end
            cur_warp <= '0;
            num_warps_q <= '0;
            started <= 1'b0;
            done <= 1'b0;
        end else begin
            if (start && !started) begin
                started <= 1'b1;
                num_warps_q <= cfg.num_warps;
                cur_warp <= '0;
                for (int i = 0; i < WARPS; i++) begin
                    if (i < int'(cfg.num_warps)) begin
                        warp_state[i] <= simt_pkg::WARP_FETCH;
                        pc[i] <= cfg.base_pc;
                    end
                end
            end else begin
                case (cur_state)
                    simt_pkg::WARP_FETCH: begin
                        if (imem_ready) begin
                            warp_state[cur_warp] <= simt_pkg::WARP_DECODE;
                        end
                    end
                    simt_pkg::WARP_DECODE: begin
                        warp_state[cur_warp] <= simt_pkg::WARP_EXECUTE;
                    end
                    simt_pkg::WARP_EXECUTE: begin
                        if (exec_fire) begin
                            if (is_halt) begin
                                warp_state[cur_warp] <= simt_pkg::WARP_DONE;
                            end else begin
                                pc[cur_warp] <= pc[cur_warp] + 1'b1;
                                warp_state[cur_warp] <= simt_pkg::WARP_FETCH;
                            end
                            cur_warp <= next_warp;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            // Sticky until reset
            done <= done | (started && all_done && !drain_busy);
        end
    end

    // Instruction capture and decode
    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            instr_q <= imem_data;
        end
        if (cur_state == simt_pkg::WARP_DECODE) begin
            decoded_q.valid  <= 1'b0;
            decoded_q.warp   <= cur_warp;
            decoded_q.opcode <= instr_q.opcode;
            decoded_q.rd     <= instr_q.rd;
            decoded_q.rs1    <= instr_q.rs1;
            decoded_q.rs2    <= instr_q.rs2;
            decoded_q.imm    <= {{(DW-16){instr_q.imm[15]}}, instr_q.imm};
        end
    end

    // Fetch request must not move while the memory stalls
    imem_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        imem_req.valid && !imem_ready |=> $stable(imem_req)
    );

endmodule
